/* filelist.f */
dcache_pkg.sv
dcache_meta_if.sv
dcache_data_if.sv
dcache_tag_array.sv
dcache_data_array.sv
dcache_ctrl.sv
dcache_top.sv
dcache_asserts.sv
tb_dcache_mem.sv
tb_dcache.sv

/* Bender.yml */
package:
  name: dcache

sources:
  - dcache_pkg.sv
  - dcache_meta_if.sv
  - dcache_data_if.sv
  - dcache_tag_array.sv
  - dcache_data_array.sv
  - dcache_ctrl.sv
  - dcache_top.sv
  - target: simulation
    files:
      - dcache_asserts.sv
      - tb_dcache_mem.sv
      - tb_dcache.sv

/* tb_dcache.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_dcache;
    import dcache_pkg::*;

    localparam int    mem_words      = 4096;
    localparam word_t fill_pattern   = 64'h5a3c_96f0_c3a5_0f69;
    localparam int    timeout_cycles = 500;

    logic    clk;
    logic    reset;
    logic    dreq_valid;
    addr_t   dreq_addr;
    strobe_t dreq_strobe;
    word_t   dreq_data;
    logic    dresp_data_ok;
    word_t   dresp_data;
    logic    creq_valid;
    logic    creq_is_write;
    addr_t   creq_addr;
    word_t   creq_data;
    logic    cresp_ready;
    logic    cresp_last;
    word_t   cresp_data;

    // stimulus table
    addr_t   tab_addr[$];
    strobe_t tab_strobe[$];
    word_t   tab_data[$];
    logic    tab_reset[$];
    string   tab_name[$];

    // memory as written back, and memory as the CPU sees it
    word_t   shadow_mem [mem_words];
    word_t   cpu_view   [mem_words];
    // cache model
    logic    m_valid [sets][ways];
    logic    m_dirty [sets][ways];
    tag_t    m_tag   [sets][ways];
    logic    m_lru   [sets];

    addr_t   exp_burst_addr[$];
    logic    exp_burst_write[$];
    addr_t   seen_burst_addr[$];
    logic    seen_burst_write[$];
    int      mon_beat;
    string   cur_name;

    dcache_top dut (.*);

    tb_dcache_mem #(
        .mem_words    (mem_words),
        .fill_pattern (fill_pattern)
    ) u_mem (.*);

    initial clk = 1'b0;
    always #4 clk = ~clk;

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("TEST RESULT: FAIL");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic add_entry(input addr_t addr, input strobe_t strobe, input word_t wdata,
                             input logic do_reset, input string name);
        tab_addr.push_back(addr);
        tab_strobe.push_back(strobe);
        tab_data.push_back(wdata);
        tab_reset.push_back(do_reset);
        tab_name.push_back(name);
    endtask

    function automatic int word_index(input addr_t addr);
        return int'((addr >> byte_bits) % mem_words);
    endfunction

    function automatic addr_t line_base(input tag_t tag, input index_t idx);
        return addr_t'({tag, idx}) << (offset_bits + byte_bits);
    endfunction

    task automatic pulse_reset;
        @(posedge clk);
        reset <= 1'b0;
        repeat (5) @(posedge clk);
        reset <= 1'b1;
    endtask

    // dirty lines are dropped, so the CPU view falls back to memory
    task automatic reset_model;
        for (int s = 0; s < sets; s++)
        begin
            m_valid[s] = '{default: 1'b0};
            m_dirty[s] = '{default: 1'b0};
            m_lru[s]   = 1'b0;
        end
        for (int i = 0; i < mem_words; i++)
            cpu_view[i] = shadow_mem[i];
    endtask

    task automatic predict_access(input addr_t addr, input strobe_t strobe, input word_t wdata,
                                  output word_t exp_rd);
        index_t idx;
        tag_t   tag;
        int     way;
        int     victim_base;
        idx = addr[byte_bits+offset_bits +: index_bits];
        tag = addr[addr_width-1 -: tag_bits];
        way = -1;
        for (int w = 0; w < ways; w++)
        begin
            if (m_valid[idx][w] && m_tag[idx][w] == tag)
                way = w;
        end
        if (way < 0)
        begin
            // first invalid way, else the least recently used one
            if (!m_valid[idx][0])
                way = 0;
            else if (!m_valid[idx][1])
                way = 1;
            else
                way = m_lru[idx];
            if (m_valid[idx][way] && m_dirty[idx][way])
            begin
                exp_burst_addr.push_back(line_base(m_tag[idx][way], idx));
                exp_burst_write.push_back(1'b1);
                victim_base = word_index(line_base(m_tag[idx][way], idx));
                for (int k = 0; k < words_per_line; k++)
                    shadow_mem[victim_base + k] = cpu_view[victim_base + k];
            end
            exp_burst_addr.push_back(line_base(tag, idx));
            exp_burst_write.push_back(1'b0);
            m_valid[idx][way] = 1'b1;
            m_dirty[idx][way] = 1'b0;
            m_tag[idx][way]   = tag;
        end
        m_lru[idx] = (way == 0);
        exp_rd = cpu_view[word_index(addr)];
        if (|strobe)
        begin
            m_dirty[idx][way] = 1'b1;
            for (int b = 0; b < strobe_width; b++)
            begin
                if (strobe[b])
                    cpu_view[word_index(addr)][b*8 +: 8] = wdata[b*8 +: 8];
            end
        end
    endtask

    task automatic wait_data_ok(input string name);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!dresp_data_ok)
        begin
            cycles++;
            if (cycles > timeout_cycles)
                fail_run($sformatf("no response from the cache within %0d cycles on %s",
                                   timeout_cycles, name));
            @(negedge clk);
        end
    endtask

    // burst monitor sampled mid-cycle
    always @(negedge clk)
    begin
        if (!reset)
            mon_beat = 0;
        else if (creq_valid && cresp_ready)
        begin
            if (mon_beat == 0)
            begin
                seen_burst_addr.push_back(creq_addr);
                seen_burst_write.push_back(creq_is_write);
            end
            if (creq_is_write)
            begin
                assert (creq_data == shadow_mem[word_index(creq_addr) + mon_beat])
                else fail_run($sformatf("ERROR %s: writeback beat %0d expected %h, actual %h",
                                        cur_name, mon_beat,
                                        shadow_mem[word_index(creq_addr) + mon_beat],
                                        creq_data));
            end
            mon_beat = cresp_last ? 0 : mon_beat + 1;
        end
    end

    initial
    begin
        word_t exp_rd;
        reset       = 1'b0;
        dreq_valid  = 1'b0;
        dreq_addr   = '0;
        dreq_strobe = '0;
        dreq_data   = '0;
        cur_name    = "reset";
        for (int i = 0; i < mem_words; i++)
            shadow_mem[i] = word_t'(i) ^ fill_pattern;
        reset_model();

        // set 2 holds tags 0, 1, 2, 3, 4, 5 in turn
        add_entry(32'h0000_0108, 8'h00, '0, 1'b0, "read miss clean set");
        add_entry(32'h0000_0108, 8'h00, '0, 1'b0, "repeat read hit");
        add_entry(32'h0000_0110, 8'h00, '0, 1'b0, "read hit next word");
        add_entry(32'h0000_0108, 8'h0f, 64'h1111_2222_3333_4444, 1'b0, "partial write hit");
        add_entry(32'h0000_0108, 8'h00, '0, 1'b0, "read merged word");
        add_entry(32'h0000_0138, 8'hf0, 64'hdead_beef_0bad_f00d, 1'b0, "upper lane write hit");
        add_entry(32'h0000_0500, 8'h00, '0, 1'b0, "second tag same set");
        add_entry(32'h0000_0908, 8'h00, '0, 1'b0, "third tag evicts dirty line");
        add_entry(32'h0000_0d10, 8'hff, 64'h0123_4567_89ab_cdef, 1'b0, "write miss clean victim");
        add_entry(32'h0000_0108, 8'h00, '0, 1'b0, "refetch of evicted dirty line");
        add_entry(32'h0000_0138, 8'h00, '0, 1'b0, "refetched upper lanes");
        add_entry(32'h0000_0d10, 8'h00, '0, 1'b0, "read back write miss");
        add_entry(32'h0000_0108, 8'h00, '0, 1'b1, "read after reset");
        add_entry(32'h0000_0d10, 8'h00, '0, 1'b0, "dirty data lost in reset");
        add_entry(32'h0000_0d18, 8'h3c, 64'hcafe_f00d_5555_aaaa, 1'b0, "middle lane write");
        add_entry(32'h0000_1110, 8'h81, 64'h8877_6655_4433_2211, 1'b0, "write miss fourth tag");
        add_entry(32'h0000_1508, 8'h00, '0, 1'b0, "evict after reset");
        add_entry(32'h0000_0d18, 8'h00, '0, 1'b0, "middle lanes refetched");
        add_entry(32'h0000_7f80, 8'h00, '0, 1'b0, "read miss other set");
        add_entry(32'h0000_7f80, 8'h22, 64'h0f0f_0f0f_f0f0_f0f0, 1'b0, "write hit other set");
        add_entry(32'h0000_7f80, 8'h00, '0, 1'b0, "read back other set");

        repeat (5) @(posedge clk);
        reset <= 1'b1;

        for (int i = 0; i < tab_addr.size(); i++)
        begin
            if (tab_reset[i])
            begin
                pulse_reset();
                reset_model();
            end
            cur_name = tab_name[i];
            exp_burst_addr.delete();
            exp_burst_write.delete();
            seen_burst_addr.delete();
            seen_burst_write.delete();
            predict_access(tab_addr[i], tab_strobe[i], tab_data[i], exp_rd);
            @(posedge clk);
            dreq_valid  <= 1'b1;
            dreq_addr   <= tab_addr[i];
            dreq_strobe <= tab_strobe[i];
            dreq_data   <= tab_data[i];
            wait_data_ok(tab_name[i]);
            if (tab_strobe[i] == '0)
            begin
                assert (dresp_data == exp_rd)
                else fail_run($sformatf("ERROR %s: read data expected %h, actual %h",
                                        tab_name[i], exp_rd, dresp_data));
            end
            assert (seen_burst_addr.size() == exp_burst_addr.size())
            else fail_run($sformatf("ERROR %s: burst count expected %0d, actual %0d",
                                    tab_name[i], exp_burst_addr.size(),
                                    seen_burst_addr.size()));
            for (int b = 0; b < exp_burst_addr.size(); b++)
            begin
                assert (seen_burst_addr[b] == exp_burst_addr[b])
                else fail_run($sformatf("ERROR %s: burst %0d address expected %h, actual %h",
                                        tab_name[i], b, exp_burst_addr[b],
                                        seen_burst_addr[b]));
                assert (seen_burst_write[b] == exp_burst_write[b])
                else fail_run($sformatf("ERROR %s: burst %0d write flag expected %0d, actual %0d",
                                        tab_name[i], b, exp_burst_write[b],
                                        seen_burst_write[b]));
            end
            @(posedge clk);
            dreq_valid  <= 1'b0;
            dreq_strobe <= '0;
        end

        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

/* tb_dcache_mem.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_dcache_mem #(
    parameter int                mem_words    = 4096,
    parameter dcache_pkg::word_t fill_pattern = '0
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              creq_valid,
    input  logic              creq_is_write,
    input  dcache_pkg::addr_t creq_addr,
    input  dcache_pkg::word_t creq_data,
    output logic              cresp_ready,
    output logic              cresp_last,
    output dcache_pkg::word_t cresp_data
);
    import dcache_pkg::*;

    word_t  mem [mem_words];
    integer seed;
    int     beat;
    int     gap;
    int     line_word;
    logic   busy;
    logic   ended;

    initial
    begin
        seed        = 34679;
        busy        = 1'b0;
        beat        = 0;
        gap         = 0;
        line_word   = 0;
        cresp_ready = 1'b0;
        cresp_last  = 1'b0;
        cresp_data  = '0;
        for (int i = 0; i < mem_words; i++)
            mem[i] = word_t'(i) ^ fill_pattern;
    end

    // writeback beats land mid-cycle, before the edge that moves them
    always @(negedge clk)
    begin
        if (reset && creq_valid && creq_is_write && cresp_ready)
            mem[line_word + beat] = creq_data;
    end

    always @(posedge clk)
    begin
        ended = 1'b0;
        if (!reset)
        begin
            busy = 1'b0;
            beat = 0;
            gap  = 0;
            cresp_ready <= 1'b0;
            cresp_last  <= 1'b0;
        end
        else
        begin
            if (cresp_ready)
            begin
                beat = beat + 1;
                if (cresp_last)
                begin
                    busy  = 1'b0;
                    beat  = 0;
                    ended = 1'b1;
                end
            end
            cresp_ready <= 1'b0;
            cresp_last  <= 1'b0;
            // creq still shows the finished burst in this cycle
            if (creq_valid && !busy && !ended)
            begin
                busy      = 1'b1;
                gap       = $unsigned($random(seed)) % 4;
                line_word = int'((creq_addr >> byte_bits) % mem_words);
            end
            if (busy)
            begin
                if (gap > 0)
                    gap = gap - 1;
                else if ($unsigned($random(seed)) % 4 != 0)
                begin
                    cresp_ready <= 1'b1;
                    cresp_last  <= (beat == words_per_line - 1);
                    cresp_data  <= mem[line_word + beat];
                end
            end
        end
    end

endmodule

`default_nettype wire

/* dcache_asserts.sv */
`timescale 1ns/1ps
`default_nettype none

module dcache_asserts (
    input logic                    clk,
    input logic                    reset,
    input dcache_pkg::ctrl_state_t state,
    input logic                    creq_valid,
    input logic                    creq_is_write,
    input dcache_pkg::addr_t       creq_addr,
    input logic                    cresp_ready,
    input logic                    cresp_last,
    input logic                    dresp_data_ok
);
    import dcache_pkg::*;

    // request fields hold until the last beat moves
    burst_stable: assert property (@(posedge clk) disable iff (!reset)
        creq_valid && !(cresp_ready && cresp_last)
        |=> creq_valid && $stable(creq_addr) && $stable(creq_is_write))
        else $error("creq_addr or creq_is_write changed inside a burst");

    data_ok_in_idle: assert property (@(posedge clk) disable iff (!reset)
        dresp_data_ok |-> state == idle)
        else $error("dresp_data_ok high outside idle");

    creq_low_after_reset: assert property (@(posedge clk) !reset |=> !creq_valid)
        else $error("creq_valid high in the cycle after reset");

endmodule

bind dcache_ctrl dcache_asserts u_asserts (
    .clk           (clk),
    .reset         (reset),
    .state         (state),
    .creq_valid    (creq_valid),
    .creq_is_write (creq_is_write),
    .creq_addr     (creq_addr),
    .cresp_ready   (cresp_ready),
    .cresp_last    (cresp_last),
    .dresp_data_ok (dresp_data_ok)
);

`default_nettype wire

/* dcache_top.sv */
`timescale 1ns/1ps
`default_nettype none

module dcache_top (
    input  logic               clk,
    input  logic               reset,
    input  logic               dreq_valid,
    input  dcache_pkg::addr_t   dreq_addr,
    input  dcache_pkg::strobe_t dreq_strobe,
    input  dcache_pkg::word_t   dreq_data,
    output logic               dresp_data_ok,
    output dcache_pkg::word_t   dresp_data,
    output logic               creq_valid,
    output logic               creq_is_write,
    output dcache_pkg::addr_t   creq_addr,
    output dcache_pkg::word_t   creq_data,
    input  logic               cresp_ready,
    input  logic               cresp_last,
    input  dcache_pkg::word_t   cresp_data
);

    dcache_meta_if meta_bus ();
    dcache_data_if data_bus ();

    // miss FSM and both bus drivers
    dcache_ctrl u_ctrl (
        .clk           (clk),
        .reset         (reset),
        .dreq_valid    (dreq_valid),
        .dreq_addr     (dreq_addr),
        .dreq_strobe   (dreq_strobe),
        .dreq_data     (dreq_data),
        .dresp_data_ok (dresp_data_ok),
        .dresp_data    (dresp_data),
        .creq_valid    (creq_valid),
        .creq_is_write (creq_is_write),
        .creq_addr     (creq_addr),
        .creq_data     (creq_data),
        .cresp_ready   (cresp_ready),
        .cresp_last    (cresp_last),
        .cresp_data    (cresp_data),
        .meta          (meta_bus.ctrl),
        .data          (data_bus.ctrl)
    );

    dcache_tag_array u_tag_array (
        .clk   (clk),
        .reset (reset),
        .meta  (meta_bus.array)
    );

    dcache_data_array u_data_array (
        .clk  (clk),
        .data (data_bus.array)
    );

endmodule

`default_nettype wire

/* dcache_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module dcache_ctrl (
    input  logic               clk,
    input  logic               reset,
    input  logic               dreq_valid,
    input  dcache_pkg::addr_t   dreq_addr,
    input  dcache_pkg::strobe_t dreq_strobe,
    input  dcache_pkg::word_t   dreq_data,
    output logic               dresp_data_ok,
    output dcache_pkg::word_t   dresp_data,
    output logic               creq_valid,
    output logic               creq_is_write,
    output dcache_pkg::addr_t   creq_addr,
    output dcache_pkg::word_t   creq_data,
    input  logic               cresp_ready,
    input  logic               cresp_last,
    input  dcache_pkg::word_t   cresp_data,
    dcache_meta_if.ctrl        meta,
    dcache_data_if.ctrl        data
);
    import dcache_pkg::*;

    ctrl_state_t state;
    offset_t     word_cnt;
    cache_addr_t req;
    cache_addr_t burst_addr;
    logic        is_write;
    logic        miss;

    // line under refill, latched on the miss
    index_t      fill_index;
    tag_t        fill_tag;
    logic        fill_way;
    tag_t        wb_tag;

    assign req.raw  = dreq_addr;
    assign is_write = |dreq_strobe;
    assign miss     = (state == idle) && dreq_valid && !meta.hit;

    assign meta.lookup_index = (state == idle) ? req.f.index : fill_index;
    assign meta.lookup_tag   = (state == idle) ? req.f.tag : fill_tag;

    // data array and metadata drive
    always_comb
    begin
        data.en           = 1'b0;
        data.strobe       = '0;
        data.wdata        = dreq_data;
        data.addr         = {req.f.index, meta.hit_way, req.f.offset};
        meta.update_en    = 1'b0;
        meta.update_way   = meta.hit_way;
        meta.update_valid = 1'b1;
        meta.update_dirty = 1'b1;
        meta.update_tag   = req.f.tag;
        meta.touch_en     = 1'b0;
        meta.touch_way    = meta.hit_way;
        if (state == idle)
        begin
            if (dreq_valid && meta.hit)
            begin
                meta.touch_en = 1'b1;
                // write hit marks the line dirty
                if (is_write)
                begin
                    data.en        = 1'b1;
                    data.strobe    = dreq_strobe;
                    meta.update_en = 1'b1;
                end
            end
        end
        else
        begin
            data.addr = {fill_index, fill_way, word_cnt};
            if (state == fetch)
            begin
                data.en     = cresp_ready;
                data.strobe = '1;
                data.wdata  = cresp_data;
                // last beat leaves the line valid and clean
                if (cresp_ready && cresp_last)
                begin
                    meta.update_en    = 1'b1;
                    meta.update_way   = fill_way;
                    meta.update_dirty = 1'b0;
                    meta.update_tag   = fill_tag;
                end
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (!reset)
        begin
            state    <= idle;
            word_cnt <= '0;
        end
        else
        begin
            unique case (state)
                idle:
                begin
                    word_cnt <= '0;
                    if (miss)
                        state <= meta.victim_dirty ? writeback : fetch;
                end
                writeback:
                begin
                    if (cresp_ready)
                    begin
                        word_cnt <= word_cnt + 1'b1;
                        if (cresp_last)
                            state <= fetch;
                    end
                end
                fetch:
                begin
                    if (cresp_ready)
                    begin
                        word_cnt <= word_cnt + 1'b1;
                        if (cresp_last)
                            state <= idle;
                    end
                end
                default:
                    state <= idle;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (miss)
        begin
            fill_index <= req.f.index;
            fill_tag   <= req.f.tag;
            fill_way   <= meta.victim_way;
            wb_tag     <= meta.victim_tag;
        end
    end

    // bursts always start at the line base
    always_comb
    begin
        burst_addr.raw     = '0;
        burst_addr.f.tag   = (state == writeback) ? wb_tag : fill_tag;
        burst_addr.f.index = fill_index;
    end

    assign dresp_data_ok = (state == idle) && dreq_valid && meta.hit;
    assign dresp_data    = data.rdata;
    assign creq_valid    = (state == writeback) || (state == fetch);
    assign creq_is_write = (state == writeback);
    assign creq_addr     = burst_addr.raw;
    assign creq_data     = data.rdata;

endmodule

`default_nettype wire

/* dcache_data_array.sv */
`timescale 1ns/1ps
`default_nettype none

module dcache_data_array (
    input logic          clk,
    dcache_data_if.array data
);
    import dcache_pkg::*;

    // all lines of all ways at {index, way, offset}
    word_t mem [2**data_addr_bits];

    // byte lanes written only where strobed
    always_ff @(posedge clk)
    begin
        if (data.en)
        begin
            for (int b = 0; b < strobe_width; b++)
            begin
                if (data.strobe[b])
                    mem[data.addr][b*8 +: 8] <= data.wdata[b*8 +: 8];
            end
        end
    end

    // zero-latency read
    assign data.rdata = mem[data.addr];

endmodule

`default_nettype wire

/* dcache_tag_array.sv */
`timescale 1ns/1ps
`default_nettype none

module dcache_tag_array (
    input logic          clk,
    input logic          reset,
    dcache_meta_if.array meta
);
    import dcache_pkg::*;

    logic [ways-1:0] valid_q [sets];
    logic [ways-1:0] dirty_q [sets];
    tag_t            tag_q   [sets][ways];
    // way used least recently in each set
    logic [sets-1:0] lru_q;

    // control bits
    always_ff @(posedge clk)
    begin
        if (!reset)
        begin
            for (int s = 0; s < sets; s++)
            begin
                valid_q[s] <= '0;
                dirty_q[s] <= '0;
            end
            lru_q <= '0;
        end
        else
        begin
            if (meta.update_en)
            begin
                valid_q[meta.lookup_index][meta.update_way] <= meta.update_valid;
                dirty_q[meta.lookup_index][meta.update_way] <= meta.update_dirty;
            end
            if (meta.touch_en)
                lru_q[meta.lookup_index] <= ~meta.touch_way;
        end
    end

    // tags written by the metadata update
    always_ff @(posedge clk)
    begin
        if (meta.update_en)
            tag_q[meta.lookup_index][meta.update_way] <= meta.update_tag;
    end

    // compare both ways of the set
    always_comb
    begin
        meta.hit     = 1'b0;
        meta.hit_way = 1'b0;
        for (int w = 0; w < ways; w++)
        begin
            if (valid_q[meta.lookup_index][w] && tag_q[meta.lookup_index][w] == meta.lookup_tag)
            begin
                meta.hit     = 1'b1;
                meta.hit_way = w[0];
            end
        end
    end

    // victim is the lowest invalid way, else the LRU way
    always_comb
    begin
        meta.victim_way = lru_q[meta.lookup_index];
        for (int w = ways - 1; w >= 0; w--)
        begin
            if (!valid_q[meta.lookup_index][w])
                meta.victim_way = w[0];
        end
        meta.victim_dirty = valid_q[meta.lookup_index][meta.victim_way]
                          & dirty_q[meta.lookup_index][meta.victim_way];
        meta.victim_tag   = tag_q[meta.lookup_index][meta.victim_way];
    end

endmodule

`default_nettype wire

/* dcache_data_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface dcache_data_if;
    import dcache_pkg::*;

    logic                      en;
    strobe_t                   strobe;
    logic [data_addr_bits-1:0] addr;
    word_t                     wdata;
    // combinational read of addr
    word_t                     rdata;

    modport ctrl (
        output en, strobe, addr, wdata,
        input  rdata
    );

    modport array (
        input  en, strobe, addr, wdata,
        output rdata
    );

endinterface

`default_nettype wire

/* dcache_meta_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface dcache_meta_if;
    import dcache_pkg::*;

    // lookup of one set
    index_t lookup_index;
    tag_t   lookup_tag;
    logic   hit;
    logic   hit_way;
    logic   victim_way;
    logic   victim_dirty;
    tag_t   victim_tag;

    // metadata write and LRU touch at lookup_index
    logic   update_en;
    logic   update_way;
    logic   update_valid;
    logic   update_dirty;
    tag_t   update_tag;
    logic   touch_en;
    logic   touch_way;

    modport ctrl (
        output lookup_index, lookup_tag,
        output update_en, update_way, update_valid, update_dirty, update_tag,
        output touch_en, touch_way,
        input  hit, hit_way, victim_way, victim_dirty, victim_tag
    );

    modport array (
        input  lookup_index, lookup_tag,
        input  update_en, update_way, update_valid, update_dirty, update_tag,
        input  touch_en, touch_way,
        output hit, hit_way, victim_way, victim_dirty, victim_tag
    );

endinterface

`default_nettype wire

/* dcache_pkg.sv */
`default_nettype none

package dcache_pkg;

    // geometry
    localparam int addr_width     = 32;
    localparam int word_width     = 64;
    localparam int strobe_width   = word_width / 8;
    localparam int ways           = 2;
    localparam int sets           = 8;
    localparam int words_per_line = 16;

    // address split
    localparam int byte_bits      = $clog2(strobe_width);
    localparam int offset_bits    = $clog2(words_per_line);
    localparam int index_bits     = $clog2(sets);
    localparam int tag_bits       = addr_width - index_bits - offset_bits - byte_bits;
    // data array address is {index, way, offset}
    localparam int data_addr_bits = index_bits + $clog2(ways) + offset_bits;

    typedef logic [addr_width-1:0]   addr_t;
    typedef logic [word_width-1:0]   word_t;
    typedef logic [strobe_width-1:0] strobe_t;
    typedef logic [tag_bits-1:0]     tag_t;
    typedef logic [index_bits-1:0]   index_t;
    typedef logic [offset_bits-1:0]  offset_t;

    // request address as raw bits or as cache fields
    typedef union packed {
        addr_t raw;
        struct packed {
            tag_t                 tag;
            index_t               index;
            offset_t              offset;
            logic [byte_bits-1:0] byte_off;
        } f;
    } cache_addr_t;

    typedef enum logic [1:0] {
        idle,
        writeback,
        fetch
    } ctrl_state_t;

endpackage

`default_nettype wire
